// ==== hdl/core_top.sv ====
module core_top (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             fetch_valid_i,
  input  rv_pkg::word_t    fetch_data_i,
  output rv_pkg::word_t    fetch_addr_o,
  output logic             fetch_req_o,
  output logic             commit_valid_o,
  output rv_pkg::word_t    commit_pc_o,
  output rv_pkg::word_t    commit_inst_o,
  output rv_pkg::reg_idx_t commit_rd_o,
  output rv_pkg::word_t    commit_data_o
);

  logic             slot_valid;
  rv_pkg::if_id_t   slot;
  logic             if_id_valid;
  rv_pkg::if_id_t   if_id_data;
  rv_pkg::reg_idx_t rs1_idx;
  rv_pkg::reg_idx_t rs2_idx;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  logic             dec_valid;
  rv_pkg::id_ex_t   dec;
  logic             id_ex_valid;
  rv_pkg::id_ex_t   id_ex_data;
  rv_pkg::word_t    ex_result;
  rv_pkg::ex_wb_t   ex_out;
  logic             redirect_valid;
  rv_pkg::word_t    redirect_pc;
  logic             ex_wb_valid;
  rv_pkg::ex_wb_t   ex_wb_data;
  logic             wb_wen;

  fetch_unit u_fetch (
    .clk              (clk),
    .reset_i          (reset_i),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_data_i     (fetch_data_i),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .fetch_addr_o     (fetch_addr_o),
    .fetch_req_o      (fetch_req_o),
    .slot_valid_o     (slot_valid),
    .slot_o           (slot)
  );

  pipe_stage_reg #(.payload_t(rv_pkg::if_id_t)) if_id (
    .clk     (clk),
    .reset_i (reset_i),
    .flush_i (redirect_valid),
    .valid_i (slot_valid),
    .data_i  (slot),
    .valid_o (if_id_valid),
    .data_o  (if_id_data)
  );

  decode_unit u_decode (
    .slot_valid_i (if_id_valid),
    .slot_i       (if_id_data),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .ex_valid_i   (id_ex_valid),
    .ex_wen_i     (id_ex_data.wen),
    .ex_rd_i      (id_ex_data.rd),
    .ex_result_i  (ex_result),
    .wb_valid_i   (ex_wb_valid),
    .wb_i         (ex_wb_data),
    .dec_valid_o  (dec_valid),
    .dec_o        (dec)
  );

  pipe_stage_reg #(.payload_t(rv_pkg::id_ex_t)) id_ex (
    .clk     (clk),
    .reset_i (reset_i),
    .flush_i (redirect_valid),
    .valid_i (dec_valid),
    .data_i  (dec),
    .valid_o (id_ex_valid),
    .data_o  (id_ex_data)
  );

  execute_unit u_execute (
    .valid_i          (id_ex_valid),
    .id_ex_i          (id_ex_data),
    .result_o         (ex_result),
    .ex_o             (ex_out),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc)
  );

  // the branch itself retires, so this stage is never flushed
  pipe_stage_reg #(.payload_t(rv_pkg::ex_wb_t)) ex_wb (
    .clk     (clk),
    .reset_i (reset_i),
    .flush_i (1'b0),
    .valid_i (id_ex_valid),
    .data_i  (ex_out),
    .valid_o (ex_wb_valid),
    .data_o  (ex_wb_data)
  );

  assign wb_wen = ex_wb_valid & ex_wb_data.wen;

  gpr_regfile u_gpr (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (wb_wen),
    .rd_i       (ex_wb_data.rd),
    .wdata_i    (ex_wb_data.result)
  );

  // commit record straight from the writeback slot
  assign commit_valid_o = ex_wb_valid;
  assign commit_pc_o    = ex_wb_data.pc;
  assign commit_inst_o  = ex_wb_data.inst;
  assign commit_rd_o    = ex_wb_data.wen ? ex_wb_data.rd : '0;
  assign commit_data_o  = ex_wb_data.result;

endmodule

// ==== hdl/decode_unit.sv ====
`include "rv_consts.svh"

module decode_unit (
  input  logic             slot_valid_i,
  input  rv_pkg::if_id_t   slot_i,
  output rv_pkg::reg_idx_t rs1_idx_o,
  output rv_pkg::reg_idx_t rs2_idx_o,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  input  logic             ex_valid_i,
  input  logic             ex_wen_i,
  input  rv_pkg::reg_idx_t ex_rd_i,
  input  rv_pkg::word_t    ex_result_i,
  input  logic             wb_valid_i,
  input  rv_pkg::ex_wb_t   wb_i,
  output logic             dec_valid_o,
  output rv_pkg::id_ex_t   dec_o
);

  rv_pkg::word_t    inst;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic             funct7_b5;
  rv_pkg::word_t    imm_i;
  rv_pkg::word_t    imm_u;
  rv_pkg::word_t    imm_b;
  rv_pkg::word_t    imm_j;
  rv_pkg::word_t    imm_sel;
  rv_pkg::word_t    rs1_fwd;
  rv_pkg::word_t    rs2_fwd;
  rv_pkg::reg_idx_t rd_idx;
  rv_pkg::alu_op_e  alu_op;
  rv_pkg::ctl_e     ctl;
  logic             wen;
  logic             use_imm;

  assign inst      = slot_i.inst;
  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];
  assign rs1_idx_o = inst[19:15];
  assign rs2_idx_o = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // youngest producer wins
  // x0 always reads the file
  function automatic rv_pkg::word_t fwd(input rv_pkg::reg_idx_t idx,
                                        input rv_pkg::word_t rf_val);
    rv_pkg::word_t val;
    val = rf_val;
    if (idx != '0) begin
      if (ex_valid_i && ex_wen_i && ex_rd_i == idx) begin
        val = ex_result_i;
      end else if (wb_valid_i && wb_i.wen && wb_i.rd == idx) begin
        val = wb_i.result;
      end
    end
    return val;
  endfunction

  always_comb begin
    rs1_fwd = fwd(rs1_idx_o, rs1_data_i);
    rs2_fwd = fwd(rs2_idx_o, rs2_data_i);
  end

  // defaults describe a no-op that passes zero and writes nothing
  always_comb begin
    alu_op  = rv_pkg::PASS_B;
    ctl     = rv_pkg::NONE;
    wen     = 1'b0;
    use_imm = 1'b1;
    imm_sel = '0;
    case (opcode)
      `OPC_OP_IMM: begin
        case (funct3)
          `F3_ADD: alu_op = rv_pkg::ADD;
          `F3_SLT: alu_op = rv_pkg::SLT;
          `F3_XOR: alu_op = rv_pkg::XOR;
          `F3_OR:  alu_op = rv_pkg::OR;
          `F3_AND: alu_op = rv_pkg::AND;
          default: alu_op = rv_pkg::PASS_B;
        endcase
        wen     = (alu_op != rv_pkg::PASS_B);
        imm_sel = wen ? imm_i : '0;
      end
      `OPC_OP: begin
        wen     = 1'b1;
        use_imm = 1'b0;
        case (funct3)
          `F3_ADD: alu_op = funct7_b5 ? rv_pkg::SUB : rv_pkg::ADD;
          `F3_SLL: alu_op = rv_pkg::SLL;
          `F3_SLT: alu_op = rv_pkg::SLT;
          `F3_XOR: alu_op = rv_pkg::XOR;
          `F3_SRL: alu_op = rv_pkg::SRL;
          `F3_OR:  alu_op = rv_pkg::OR;
          `F3_AND: alu_op = rv_pkg::AND;
          default: begin
            wen     = 1'b0;  // sltu
            use_imm = 1'b1;
          end
        endcase
        if (funct3 == `F3_SRL && funct7_b5) begin
          alu_op  = rv_pkg::PASS_B;  // sra not in the subset
          wen     = 1'b0;
          use_imm = 1'b1;
        end
      end
      `OPC_LUI: begin
        wen     = 1'b1;
        imm_sel = imm_u;
      end
      `OPC_BRANCH: begin
        if (funct3 == `F3_BEQ) ctl = rv_pkg::BEQ;
        else if (funct3 == `F3_BNE) ctl = rv_pkg::BNE;
      end
      `OPC_JAL: begin
        ctl = rv_pkg::JAL;
        wen = 1'b1;  // link value comes from execute
      end
      default: ;
    endcase
  end

  assign rd_idx = wen ? inst[11:7] : '0;

  assign dec_valid_o = slot_valid_i;
  assign dec_o = '{
    pc:            slot_i.pc,
    inst:          inst,
    rd:            rd_idx,
    wen:           wen,
    alu_op:        alu_op,
    ctl:           ctl,
    op_a:          rs1_fwd,
    op_b:          use_imm ? imm_sel : rs2_fwd,
    rs2_val:       rs2_fwd,
    branch_target: slot_i.pc + ((ctl == rv_pkg::JAL) ? imm_j : imm_b)
  };

endmodule

// ==== hdl/execute_unit.sv ====
module execute_unit (
  input  logic           valid_i,
  input  rv_pkg::id_ex_t id_ex_i,
  output rv_pkg::word_t  result_o,
  output rv_pkg::ex_wb_t ex_o,
  output logic           redirect_valid_o,
  output rv_pkg::word_t  redirect_pc_o
);

  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::word_t alu_out;
  logic          taken;

  assign a = id_ex_i.op_a;
  assign b = id_ex_i.op_b;

  always_comb begin
    case (id_ex_i.alu_op)
      rv_pkg::ADD: alu_out = a + b;
      rv_pkg::SUB: alu_out = a - b;
      rv_pkg::AND: alu_out = a & b;
      rv_pkg::OR:  alu_out = a | b;
      rv_pkg::XOR: alu_out = a ^ b;
      rv_pkg::SLT: alu_out = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::SLL: alu_out = a << b[4:0];  // shamt is the low five bits
      rv_pkg::SRL: alu_out = a >> b[4:0];
      default:     alu_out = b;
    endcase
  end

  // branch outcome uses the raw rs2 value
  always_comb begin
    case (id_ex_i.ctl)
      rv_pkg::BEQ: taken = (a == id_ex_i.rs2_val);
      rv_pkg::BNE: taken = (a != id_ex_i.rs2_val);
      rv_pkg::JAL: taken = 1'b1;
      default:     taken = 1'b0;
    endcase
  end

  assign result_o = (id_ex_i.ctl == rv_pkg::JAL) ? id_ex_i.pc + 32'd4 : alu_out;

  // a bubble must never steer the pc
  assign redirect_valid_o = valid_i & taken;
  assign redirect_pc_o    = id_ex_i.branch_target;

  assign ex_o = '{
    pc:     id_ex_i.pc,
    inst:   id_ex_i.inst,
    rd:     id_ex_i.rd,
    wen:    id_ex_i.wen,
    result: result_o
  };

endmodule

// ==== hdl/fetch_unit.sv ====
`include "rv_consts.svh"

module fetch_unit (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           fetch_valid_i,
  input  rv_pkg::word_t  fetch_data_i,
  input  logic           redirect_valid_i,
  input  rv_pkg::word_t  redirect_pc_i,
  output rv_pkg::word_t  fetch_addr_o,
  output logic           fetch_req_o,
  output logic           slot_valid_o,
  output rv_pkg::if_id_t slot_o
);

  rv_pkg::word_t pc_q;    // address the memory is answering now
  logic          live_q;  // low until the first post-reset request is out
  logic          accept;

  // a word seen while live_q is low answers an address sampled in reset
  assign accept = fetch_valid_i & live_q;

  // next fetch address, sampled by the memory at the coming edge
  always_comb begin
    if (redirect_valid_i) begin
      fetch_addr_o = redirect_pc_i;
    end else if (accept) begin
      fetch_addr_o = pc_q + 32'd4;
    end else begin
      fetch_addr_o = pc_q;  // hold the address while waiting
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q   <= `RESET_PC;
      live_q <= 1'b0;
    end else begin
      pc_q   <= fetch_addr_o;
      live_q <= 1'b1;
    end
  end

  assign fetch_req_o = 1'b1;  // fetch never idles

  // word in flight during a redirect is wrong-path
  assign slot_valid_o = accept & ~redirect_valid_i;
  assign slot_o = '{pc: pc_q, inst: slot_valid_o ? fetch_data_i : `INST_NOP};

  a_addr_hold: assert property (
    @(posedge clk) disable iff (reset_i)
    live_q && !fetch_valid_i && !redirect_valid_i |-> fetch_addr_o == $past(fetch_addr_o)
  );

endmodule

// ==== hdl/gpr_regfile.sv ====
`include "rv_consts.svh"

module gpr_regfile (
  input  logic             clk,
  input  logic             reset_i,
  input  rv_pkg::reg_idx_t rs1_idx_i,
  input  rv_pkg::reg_idx_t rs2_idx_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o,
  input  logic             wen_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::word_t    wdata_i
);

  localparam int NUM_REGS = 1 << `REG_IDX_W;

  rv_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin  // x0 is hardwired
      regs[rd_i] <= wdata_i;
    end
  end

  // same-cycle writes reach decode through forwarding
  assign rs1_data_o = regs[rs1_idx_i];
  assign rs2_data_o = regs[rs2_idx_i];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset_i) regs[0] == '0);

endmodule

// ==== hdl/pipe_stage_reg.sv ====
module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // valid bit is the only control state here
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i & ~flush_i;  // flushed slot becomes a bubble
    end
  end

  always_ff @(posedge clk) begin
    data_o <= data_i;
  end

  // a flushed slot never shows up as valid in the next stage
  a_flush_kills: assert property (
    @(posedge clk) disable iff (reset_i)
    flush_i |=> !valid_o
  );

endmodule

// ==== hdl/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0]      word_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // alu function selected in decode
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    PASS_B  // lui and no-ops
  } alu_op_e;

  // control transfer kind, resolved in execute
  typedef enum logic [1:0] {
    NONE,
    BEQ,
    BNE,
    JAL
  } ctl_e;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    reg_idx_t rd;
    logic     wen;
    alu_op_e  alu_op;
    ctl_e     ctl;
    word_t    op_a;
    word_t    op_b;
    word_t    rs2_val;        // compare operand for beq/bne
    word_t    branch_target;
  } id_ex_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    reg_idx_t rd;
    logic     wen;
    word_t    result;
  } ex_wb_t;

endpackage

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths
`define XLEN      32
`define REG_IDX_W 5

`define RESET_PC  32'h0000_0000
`define INST_NOP  32'h0000_0013  // addi x0, x0, 0

// major opcodes of the supported subset
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

// funct3 codes
`define F3_ADD 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_XOR 3'b100
`define F3_SRL 3'b101
`define F3_OR  3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001

`endif

// ==== run_sim.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_tb_sim
./obj_dir/core_tb_sim > sim.log
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== verif/commit_checker.sv ====
`include "rv_consts.svh"

module commit_checker (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             commit_valid_o,
  input  rv_pkg::word_t    commit_pc_o,
  input  rv_pkg::word_t    commit_inst_o,
  input  rv_pkg::reg_idx_t commit_rd_o,
  input  rv_pkg::word_t    commit_data_o,
  output logic             done_o,
  output int               err_count_o
);

  localparam int MAX_REC = 64;
  localparam int MAX_GRP = 16;

  int               exp_grp  [MAX_REC];
  rv_pkg::word_t    exp_pc   [MAX_REC];
  rv_pkg::word_t    exp_inst [MAX_REC];
  rv_pkg::reg_idx_t exp_rd   [MAX_REC];
  rv_pkg::word_t    exp_data [MAX_REC];
  logic [127:0]     grp_name [MAX_GRP];

  int num_exp = 0;
  int idx = 0;
  int grp_errs = 0;
  int grp_recs = 0;
  int num_tests = 0;

  initial begin
    done_o = 1'b0;
    err_count_o = 0;
  end

  task automatic name_group(input int g, input logic [127:0] name);
    grp_name[g] = name;
  endtask

  task automatic push_record(input int g, input rv_pkg::word_t pc, input rv_pkg::reg_idx_t rd,
                             input rv_pkg::word_t data, input rv_pkg::word_t inst);
    exp_grp[num_exp]  = g;
    exp_pc[num_exp]   = pc;
    exp_rd[num_exp]   = rd;
    exp_data[num_exp] = data;
    exp_inst[num_exp] = inst;
    num_exp++;
  endtask

  task automatic report_mismatch(input string sig, input rv_pkg::word_t expv,
                                 input rv_pkg::word_t gotv);
    $display("mismatch at %0t: %s expected %h got %h (record %0d)", $time, sig, expv, gotv,
             idx);
    err_count_o++;
    grp_errs++;
  endtask

  // commit outputs are stable at the falling edge
  always @(negedge clk) begin
    if (reset_i) begin
      if (commit_valid_o === 1'b1) begin
        $display("mismatch at %0t: commit_valid_o expected %b got %b during reset", $time,
                 1'b0, commit_valid_o);
        err_count_o++;
      end
    end else if (commit_valid_o && idx < num_exp) begin
      if (commit_pc_o !== exp_pc[idx]) report_mismatch("commit_pc_o", exp_pc[idx], commit_pc_o);
      if (commit_inst_o !== exp_inst[idx]) begin
        report_mismatch("commit_inst_o", exp_inst[idx], commit_inst_o);
      end
      if (commit_rd_o !== exp_rd[idx]) begin
        report_mismatch("commit_rd_o", {27'b0, exp_rd[idx]}, {27'b0, commit_rd_o});
      end
      // data is architectural only when a register is written
      if (exp_rd[idx] != '0 && commit_data_o !== exp_data[idx]) begin
        report_mismatch("commit_data_o", exp_data[idx], commit_data_o);
      end
      grp_recs++;
      idx++;
      if (idx == num_exp || exp_grp[idx] != exp_grp[idx-1]) begin
        $display("test %0s: %s, %0d records, %0d errors", grp_name[exp_grp[idx-1]],
                 (grp_errs == 0) ? "ok" : "FAILED", grp_recs, grp_errs);
        num_tests++;
        grp_errs = 0;
        grp_recs = 0;
      end
      if (idx == num_exp) done_o = 1'b1;
    end
  end

  task automatic final_report(input logic timed_out);
    if (timed_out) begin
      $display("timeout: only %0d of %0d commit records arrived", idx, num_exp);
      err_count_o++;
    end
    $display("summary: %0d tests, %0d of %0d records checked, %0d errors", num_tests, idx,
             num_exp, err_count_o);
  endtask

endmodule

// ==== verif/core_tb.sv ====
`include "rv_consts.svh"

module core_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 3;
  localparam int MEM_WORDS = 256;
  localparam logic [31:0] LCG_MUL = 32'd1103515245;
  localparam logic [31:0] LCG_INC = 32'd12345;
  localparam logic [31:0] LCG_SEED = 32'd33016;

  logic             clk;
  logic             reset_i;
  logic             fetch_valid_i;
  rv_pkg::word_t    fetch_data_i;
  rv_pkg::word_t    fetch_addr_o;
  logic             fetch_req_o;
  logic             commit_valid_o;
  rv_pkg::word_t    commit_pc_o;
  rv_pkg::word_t    commit_inst_o;
  rv_pkg::reg_idx_t commit_rd_o;
  rv_pkg::word_t    commit_data_o;
  logic             done;
  int               err_count;

  rv_pkg::word_t mem [MEM_WORDS];
  logic [31:0]   lcg_state;
  int            cycles;
  int            limit;

  core_top dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_data_i   (fetch_data_i),
    .fetch_addr_o   (fetch_addr_o),
    .fetch_req_o    (fetch_req_o),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  commit_checker chk (
    .clk            (clk),
    .reset_i        (reset_i),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o),
    .done_o         (done),
    .err_count_o    (err_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * LCG_MUL + LCG_INC;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory answers the address seen at each edge
  // the LCG stalls it about one cycle in four
  always @(posedge clk) begin
    lcg_state     <= lcg_next(lcg_state);
    fetch_valid_i <= fetch_req_o && (lcg_state[17:16] != 2'b00);  // only requested words
    fetch_data_i  <= mem[fetch_addr_o[9:2]];
  end

  task automatic load_vectors(output int n_rec);
    int            fd;
    int            g;
    int            rd;
    logic [31:0]   a;
    logic [31:0]   w;
    logic [127:0]  name;
    string         line;
    n_rec = 0;
    fd = $fopen("verif/program_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/program_vectors.txt");
      n_rec = -1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0) begin
        if (line.getc(0) == "I") begin
          void'($sscanf(line, "I %h %h", a, w));
          mem[a[9:2]] = w;
        end else if (line.getc(0) == "T") begin
          void'($sscanf(line, "T %d %s", g, name));
          chk.name_group(g, name);
        end else if (line.getc(0) == "C") begin
          void'($sscanf(line, "C %d %h %d %h", g, a, rd, w));
          chk.push_record(g, a, rd[4:0], w, mem[a[9:2]]);
          n_rec++;
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int n_rec;
    reset_i       = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_data_i  = '0;
    lcg_state     = LCG_SEED;
    cycles        = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h0bad_0000 | i;  // never reached on the right path
    end
    load_vectors(n_rec);
    if (n_rec <= 0) begin
      $display("no expected records loaded");
      $display("Regression failed");
      $finish;
    end else begin
      limit = 8 * n_rec + 20;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_i <= 1'b0;
      while (!done && cycles < limit) begin
        @(posedge clk);
        cycles++;
      end
      chk.final_report(!done);
      if (done && err_count == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

// ==== verif/program_vectors.txt ====
# I <addr hex> <word hex> : program word
# T <group> <name> : test name, C <group> <pc hex> <rd dec> <data hex> : expected commit
I 00 00500093
I 04 FFD00113
I 08 0FF17193
I 0C 1000E213
I 10 00F1C293
I 14 00012313
I 18 123453B7
I 1C 00208433
I 20 401404B3
I 24 00809533
I 28 0083D5B3
I 2C 0014A633
I 30 00B646B3
I 34 0046F733
I 38 00A767B3
I 3C 00708013
I 40 00000833
I 44 00208463
I 48 00209463
I 4C 06300893
I 50 00840463
I 54 06300893
I 58 0080096F
I 5C 06300893
I 60 000909B3
I 64 00081463
I 68 0000006F
T 1 reset_alu_imm
T 2 reg_ops_forwarding
T 3 x0_writes
T 4 branches_jal
C 1 00 1 00000005
C 1 04 2 FFFFFFFD
C 1 08 3 000000FD
C 1 0C 4 00000105
C 1 10 5 000000F2
C 1 14 6 00000001
C 1 18 7 12345000
C 2 1C 8 00000002
C 2 20 9 FFFFFFFD
C 2 24 10 00000014
C 2 28 11 048D1400
C 2 2C 12 00000001
C 2 30 13 048D1401
C 2 34 14 00000001
C 2 38 15 00000015
C 3 3C 0 00000000
C 3 40 16 00000000
C 4 44 0 00000000
C 4 48 0 00000000
C 4 50 0 00000000
C 4 58 18 0000005C
C 4 60 19 0000005C
C 4 64 0 00000000
C 4 68 0 00000000

// ==== verilog.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/pipe_stage_reg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/gpr_regfile.sv
hdl/execute_unit.sv
hdl/core_top.sv
verif/commit_checker.sv
verif/core_tb.sv
